// File: Makefile
TOP = vic_tb

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f flist.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// File: flist.f
+incdir+hdl
hdl/vic_pkg.sv
hdl/vic_ctrl_if.sv
hdl/phase_gen.sv
hdl/raster_timing.sv
hdl/vic_registers.sv
hdl/fetch_sequencer.sv
hdl/vic_top.sv
testbench/vic_sva.sv
testbench/vic_tb.sv

// File: hdl/fetch_sequencer.sv
`timescale 1ns/1ps

`include "vic_config.svh"

module fetch_sequencer (
    input  logic        sys_clock,
    input  logic        internal_rst,
    input  logic        phi,
    input  logic        phi_fall,
    input  logic [4:0]  phase,   // phi cycle position
    vic_ctrl_if.fetch   ctrl,
    output logic        ba,      // low while a bad line steals the bus
    output logic        aec,     // low during stolen phi high halves
    output logic [11:0] ado,     // fetch address
    output logic        ado_oe,
    output logic        ras,
    output logic        cas
);

    localparam logic [6:0] CYC_LAST  = 7'(`VIC_CYCLES_PER_LINE - 1);
    localparam logic [6:0] BA_PREV   = 7'(`VIC_BA_CYCLE - 1);  // cycle before ba drops
    localparam logic [6:0] FE_FIRST  = 7'(`VIC_FETCH_FIRST);
    localparam logic [6:0] FE_LAST   = 7'(`VIC_FETCH_LAST);
    localparam logic [8:0] BL_FIRST  = 9'(`VIC_BADLINE_FIRST);
    localparam logic [8:0] BL_LAST   = 9'(`VIC_BADLINE_LAST);
    localparam logic [11:0] VM_BASE  = `VIC_VM_BASE;

    logic [6:0] cycle;       // own copy, tracks raster_timing
    logic       bad_cond;    // bad line test on the live line
    logic       bad_line;    // ba window active
    logic       fetch_win;   // cycles 15..54
    logic       fetch_act;   // chip owns the bus now
    logic [9:0] vc;          // video counter

    assign bad_cond = ctrl.den && (ctrl.raster_line >= BL_FIRST) &&
                      (ctrl.raster_line <= BL_LAST) &&
                      (ctrl.raster_line[2:0] == ctrl.yscroll);

    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            cycle    <= 7'd0;
            bad_line <= 1'b0;
        end else if (phi_fall) begin
            cycle <= (cycle == CYC_LAST) ? 7'd0 : cycle + 7'd1;
            if (cycle == BA_PREV) begin
                bad_line <= bad_cond;  // checked once per line
            end else if (cycle == FE_LAST) begin
                bad_line <= 1'b0;      // bus back after last fetch
            end
        end
    end

    assign fetch_win = (cycle >= FE_FIRST) && (cycle <= FE_LAST);
    assign fetch_act = bad_line && fetch_win && phi;

    // video counter, cleared on line 0, runs on across bad lines
    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            vc <= 10'd0;
        end else if (ctrl.raster_line == 9'd0) begin
            vc <= 10'd0;
        end else if (phi_fall && fetch_act) begin
            vc <= vc + 10'd1;  // one step per fetch
        end
    end

    assign ba     = ~bad_line;
    assign aec    = ~fetch_act;
    assign ado_oe = fetch_act;
    assign ado    = VM_BASE + {2'b00, vc};

    // ras low on 4..15 and 20..31, cas low on 8..15 and 24..31
    assign ras = ~(|phase[3:2]);
    assign cas = ~phase[3];

endmodule

// File: hdl/phase_gen.sv
`timescale 1ns/1ps

module phase_gen (
    input  logic       sys_clock,
    input  logic       internal_rst,
    output logic       dot_en,     // one pulse per 4 clocks
    output logic       phi,        // cpu phase clock
    output logic       phi_rise,   // one clock before phi goes high
    output logic       phi_fall,   // one clock before phi goes low
    output logic [4:0] phase       // position inside the phi cycle
);

    localparam logic [4:0] PHI_HIGH_AT = 5'd15;  // last low count
    localparam logic [4:0] PHI_LOW_AT  = 5'd31;  // last high count

    logic [4:0] phase_nxt;

    assign phase_nxt = phase + 5'd1;  // free running, wraps at 32

    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            phase    <= 5'd0;
            phi      <= 1'b0;  // phi starts low
            phi_rise <= 1'b0;
            phi_fall <= 1'b0;
            dot_en   <= 1'b0;
        end else begin
            phase    <= phase_nxt;
            dot_en   <= (phase_nxt[1:0] == 2'd3);   // high on counts 3, 7, 11 ...
            phi_rise <= (phase_nxt == PHI_HIGH_AT); // strobe sits on count 15
            phi_fall <= (phase_nxt == PHI_LOW_AT);  // strobe sits on count 31
            if (phase == PHI_HIGH_AT) begin
                phi <= 1'b1;  // high for 16..31
            end else if (phase == PHI_LOW_AT) begin
                phi <= 1'b0;  // low for 0..15
            end
        end
    end

    // phi is fully registered so that the output pin carries no decode glitches.
    // the two strobes are registered from the next count, which places them
    // exactly on the last clock of each half cycle
    // dot_en is one quarter of the pixel rate grid

endmodule

// File: hdl/raster_timing.sv
`timescale 1ns/1ps

`include "vic_config.svh"

module raster_timing (
    input  logic          sys_clock,
    input  logic          internal_rst,
    input  logic          phi_fall,
    vic_ctrl_if.timing    ctrl,
    output logic          csync,   // composite sync, low active
    output vic_pkg::rgb_t rgb      // registered pixel colour
);
    import vic_pkg::*;

    localparam logic [6:0] CYC_LAST   = 7'(`VIC_CYCLES_PER_LINE - 1);
    localparam logic [8:0] LINE_LAST  = 9'(`VIC_LINES_PER_FRAME - 1);
    localparam logic [6:0] HS_FIRST   = 7'(`VIC_HSYNC_FIRST);
    localparam logic [6:0] HS_LAST    = 7'(`VIC_HSYNC_LAST);
    localparam logic [8:0] VS_LAST    = 9'(`VIC_VSYNC_LAST);
    localparam logic [8:0] DL_FIRST   = 9'(`VIC_DISP_LINE_FIRST);
    localparam logic [8:0] DL_LAST    = 9'(`VIC_DISP_LINE_LAST);
    localparam logic [6:0] DC_FIRST   = 7'(`VIC_DISP_CYC_FIRST);
    localparam logic [6:0] DC_LAST    = 7'(`VIC_DISP_CYC_LAST);

    logic [6:0] cycle;       // 0..64
    logic [8:0] line;        // 0..262
    logic [6:0] cycle_nxt;
    logic [8:0] line_nxt;
    logic       line_end;    // last cycle of the line
    logic       hsync_nxt;
    logic       vsync_nxt;
    logic       disp_nxt;    // next cycle inside display window
    color_t     pix_color;

    // next counter values, taken on phi_fall
    always_comb begin
        line_end  = (cycle == CYC_LAST);
        cycle_nxt = line_end ? 7'd0 : cycle + 7'd1;
        if (!line_end) begin
            line_nxt = line;                 // same line
        end else if (line == LINE_LAST) begin
            line_nxt = 9'd0;                 // new frame
        end else begin
            line_nxt = line + 9'd1;
        end
    end

    // sync and window decode on the next position
    assign hsync_nxt = (cycle_nxt >= HS_FIRST) && (cycle_nxt <= HS_LAST);
    assign vsync_nxt = (line_nxt <= VS_LAST);
    assign disp_nxt  = (line_nxt >= DL_FIRST) && (line_nxt <= DL_LAST) &&
                       (cycle_nxt >= DC_FIRST) && (cycle_nxt <= DC_LAST);
    assign pix_color = disp_nxt ? ctrl.background : ctrl.border;

    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            cycle <= 7'd0;
            line  <= 9'd0;
            csync <= 1'b1;  // idle high
            rgb   <= '0;    // black
        end else if (phi_fall) begin
            cycle <= cycle_nxt;
            line  <= line_nxt;
            csync <= ~(hsync_nxt | vsync_nxt);               // vsync lines stay low
            rgb   <= vsync_nxt ? rgb_t'('0) : palette(pix_color); // blank in vsync
        end
    end

    // compare hit, one clock, lined up with the new line value
    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            ctrl.raster_match <= 1'b0;
        end else begin
            ctrl.raster_match <= phi_fall && line_end && (line_nxt == ctrl.raster_cmp);
        end
    end

    assign ctrl.raster_line = line;  // live line for reads and fetch

endmodule

// File: hdl/vic_config.svh
`ifndef VIC_CONFIG_SVH
`define VIC_CONFIG_SVH

// ntsc 6567 frame geometry
`define VIC_CYCLES_PER_LINE 65   // phi cycles per raster line
`define VIC_LINES_PER_FRAME 263  // lines per frame

`define VIC_HSYNC_FIRST     58   // first cycle with csync low
`define VIC_HSYNC_LAST      61   // last cycle with csync low
`define VIC_VSYNC_LAST      2    // lines 0..2 are all sync

`define VIC_DISP_LINE_FIRST 51   // display window, lines
`define VIC_DISP_LINE_LAST  250
`define VIC_DISP_CYC_FIRST  16   // display window, cycles
`define VIC_DISP_CYC_LAST   55

`define VIC_BADLINE_FIRST   48   // lines that may be bad lines
`define VIC_BADLINE_LAST    247
`define VIC_BA_CYCLE        12   // ba drops at start of this cycle
`define VIC_FETCH_FIRST     15   // first stolen cycle
`define VIC_FETCH_LAST      54   // last stolen cycle
`define VIC_VM_BASE         12'h400 // video matrix base

`endif

// File: hdl/vic_ctrl_if.sv
`timescale 1ns/1ps

interface vic_ctrl_if;
    import vic_pkg::*;

    color_t     border;        // border colour index
    color_t     background;    // background colour index
    logic [8:0] raster_cmp;    // interrupt compare line
    logic       den;           // display enable
    logic [2:0] yscroll;       // bad line phase
    logic [8:0] raster_line;   // live line count
    logic       raster_match;  // one clock on compare hit

    modport regs (
        output border, background, raster_cmp, den, yscroll,
        input  raster_line, raster_match
    );

    modport timing (input border, background, raster_cmp, output raster_line, raster_match);

    modport fetch (input den, yscroll, raster_line);

endinterface

// File: hdl/vic_pkg.sv
package vic_pkg;

    // register map, low 6 address bits
    typedef enum logic [5:0] {
        CTRL1      = 6'h11,  // rst8, den, yscroll
        RASTER     = 6'h12,  // raster compare / live line
        IRQ_STATUS = 6'h19,  // write 1 to clear
        IRQ_ENABLE = 6'h1A,
        BORDER     = 6'h20,
        BACKGROUND = 6'h21
    } reg_addr_e;

    typedef logic [3:0] color_t;  // palette index

    typedef struct packed {
        logic [1:0] red;
        logic [1:0] green;
        logic [1:0] blue;
    } rgb_t;

    // 2 bits per gun, {r, g, b}
    localparam logic [5:0] PALETTE [16] = '{
        6'b00_00_00, 6'b11_11_11, 6'b10_00_00, 6'b10_11_11,  // black white red cyan
        6'b11_01_11, 6'b00_11_01, 6'b00_00_10, 6'b11_11_01,  // purple green blue yellow
        6'b11_10_01, 6'b01_01_00, 6'b11_01_01, 6'b01_01_01,  // orange brown lt red dk grey
        6'b10_10_10, 6'b10_11_01, 6'b00_10_11, 6'b10_10_10   // grey lt green lt blue lt grey
    };

    function automatic rgb_t palette(input color_t c);
        rgb_t p;
        p = rgb_t'(PALETTE[c]);  // table lookup
        return p;
    endfunction

endpackage

// File: hdl/vic_registers.sv
`timescale 1ns/1ps

module vic_registers (
    input  logic        sys_clock,
    input  logic        internal_rst,
    input  logic        phi,
    input  logic        phi_fall,
    input  logic [5:0]  adi,   // register select
    input  logic [11:0] dbi,   // write data
    output logic [11:0] dbo,   // read data
    input  logic        ce,    // low active select
    input  logic        rw,    // high read, low write
    input  logic        aec,   // low while the chip owns the bus
    vic_ctrl_if.regs    ctrl,
    output logic        irq    // low active
);
    import vic_pkg::*;

    reg_addr_e  addr;
    logic       wr_en;       // write strobe at end of phi high
    logic       rd_en;       // cpu read phase
    logic [6:0] ctrl1_lo;    // ctrl1 bits 6..0
    logic [8:0] raster_cmp;
    logic       irq_en;      // raster interrupt enable
    logic       irq_status;  // raster interrupt latch
    color_t     border;
    color_t     background;
    logic [7:0] rd_data;

    assign addr  = reg_addr_e'(adi);
    assign wr_en = phi_fall & ~ce & aec & ~rw;
    assign rd_en = phi & ~ce & aec & rw;

    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            ctrl1_lo   <= 7'd0;
            raster_cmp <= 9'd0;
            irq_en     <= 1'b0;
            border     <= 4'd0;
            background <= 4'd0;
        end else if (wr_en) begin
            case (addr)
                CTRL1: begin
                    ctrl1_lo      <= dbi[6:0];
                    raster_cmp[8] <= dbi[7];     // compare bit 8 lives here
                end
                RASTER:     raster_cmp[7:0] <= dbi[7:0];
                IRQ_ENABLE: irq_en          <= dbi[0];
                BORDER:     border          <= dbi[3:0];
                BACKGROUND: background      <= dbi[3:0];
                default:    ;                  // status handled below
            endcase
        end
    end

    // raster interrupt latch
    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            irq_status <= 1'b0;
        end else if (ctrl.raster_match) begin
            irq_status <= 1'b1;  // new hit wins over a clear
        end else if (wr_en && (addr == IRQ_STATUS) && dbi[0]) begin
            irq_status <= 1'b0;  // write one to ack
        end
    end

    assign irq = ~(irq_status & irq_en);

    // read mux, unused bits read as ones
    always_comb begin
        rd_data = 8'hFF;
        case (addr)
            CTRL1:      rd_data = {ctrl.raster_line[8], ctrl1_lo};
            RASTER:     rd_data = ctrl.raster_line[7:0];
            IRQ_STATUS: rd_data = {~irq, 6'h3F, irq_status};  // bit 7 any pending
            IRQ_ENABLE: rd_data = {7'h7F, irq_en};
            BORDER:     rd_data = {4'hF, border};
            BACKGROUND: rd_data = {4'hF, background};
            default:    rd_data = 8'hFF;
        endcase
    end

    assign dbo = rd_en ? {4'hF, rd_data} : 12'hFFF;  // idle bus reads high

    // settings out to timing and fetch
    assign ctrl.border     = border;
    assign ctrl.background = background;
    assign ctrl.raster_cmp = raster_cmp;
    assign ctrl.den        = ctrl1_lo[4];
    assign ctrl.yscroll    = ctrl1_lo[2:0];

endmodule

// File: hdl/vic_top.sv
`timescale 1ns/1ps

module vic_top (
    input  logic        sys_clock,
    input  logic        internal_rst,
    output logic        clk_phi,   // phi to the cpu
    output logic        csync,     // composite sync
    output logic [1:0]  red,
    output logic [1:0]  green,
    output logic [1:0]  blue,
    input  logic [5:0]  adi,       // cpu register address
    output logic [11:0] ado,       // fetch address
    output logic        ado_oe,    // address drive enable
    input  logic [11:0] dbi,       // data bus in
    output logic [11:0] dbo,       // data bus out
    output logic        db_oe,     // data drive enable
    input  logic        ce,        // low active
    input  logic        rw,        // high read
    output logic        irq,       // low active
    output logic        aec,
    output logic        ba,
    output logic        cas,
    output logic        ras,
    output logic        den_n,     // bus transceiver enable
    output logic        dir        // bus transceiver direction
);
    import vic_pkg::*;

    logic       phi;
    logic       phi_fall;
    logic [4:0] phase;
    rgb_t       pix;  // registered colour from raster block

    vic_ctrl_if ctrl_bus ();

    phase_gen u_phase (
        .sys_clock    (sys_clock),
        .internal_rst (internal_rst),
        .dot_en       (),          // pixel grid, no pixel fetch in this model
        .phi          (phi),
        .phi_rise     (),          // no block works on the rising strobe
        .phi_fall     (phi_fall),
        .phase        (phase)
    );

    raster_timing u_raster (
        .sys_clock    (sys_clock),
        .internal_rst (internal_rst),
        .phi_fall     (phi_fall),
        .ctrl         (ctrl_bus.timing),
        .csync        (csync),
        .rgb          (pix)
    );

    vic_registers u_regs (
        .sys_clock (sys_clock), .internal_rst (internal_rst),
        .phi (phi), .phi_fall (phi_fall),
        .adi (adi), .dbi (dbi), .dbo (dbo),
        .ce (ce), .rw (rw), .aec (aec),
        .ctrl (ctrl_bus.regs), .irq (irq)
    );

    fetch_sequencer u_fetch (
        .sys_clock (sys_clock), .internal_rst (internal_rst),
        .phi (phi), .phi_fall (phi_fall), .phase (phase),
        .ctrl (ctrl_bus.fetch),
        .ba (ba), .aec (aec), .ado (ado), .ado_oe (ado_oe),
        .ras (ras), .cas (cas)
    );

    assign clk_phi = phi;
    assign {red, green, blue} = {pix.red, pix.green, pix.blue};
    assign db_oe = aec & rw & ~ce & phi;  // cpu read in phi high
    assign den_n = ce & aec;              // low on cpu select or stolen cycle
    assign dir   = db_oe;                 // chip drives toward cpu

endmodule

// File: testbench/vic_sva.sv
`timescale 1ns/1ps

`include "vic_config.svh"

module vic_sva (
    input logic       sys_clock,
    input logic       internal_rst,
    input logic       clk_phi,
    input logic       phi_fall,
    input logic [4:0] phase,
    input logic       ba,
    input logic       aec,
    input logic       csync,
    input logic       ras,
    input logic       cas
);

    logic       phi_q;      // phi one clock back
    logic [5:0] run_len;    // clocks at the current phi level
    logic       synced;     // a full phi half has been seen
    logic       started;    // first phi fall passed
    int         cycle;      // own raster position
    int         line;

    always_ff @(posedge sys_clock) begin
        if (internal_rst) begin
            phi_q   <= 1'b0;
            run_len <= 6'd0;
            synced  <= 1'b0;
            started <= 1'b0;
            cycle   <= 0;
            line    <= 0;
        end else begin
            phi_q   <= clk_phi;
            run_len <= (clk_phi != phi_q) ? 6'd1 : run_len + 6'd1;
            if (clk_phi != phi_q) synced <= 1'b1;
            if (phi_fall) begin
                started <= 1'b1;
                cycle   <= (cycle == `VIC_CYCLES_PER_LINE - 1) ? 0 : cycle + 1;
                if (cycle == `VIC_CYCLES_PER_LINE - 1) begin
                    line <= (line == `VIC_LINES_PER_FRAME - 1) ? 0 : line + 1;
                end
            end
        end
    end

    // every phi half lasts 16 clocks
    a_phi_half: assert property (@(posedge sys_clock) disable iff (internal_rst)
        (synced && clk_phi != phi_q) |-> run_len == 6'd16)
        else $error("phi half period is not 16 clocks");

    a_ras: assert property (@(posedge sys_clock) disable iff (internal_rst)
        ras == !(phase[3:0] >= 4'd4))
        else $error("ras out of its phase window");

    a_cas: assert property (@(posedge sys_clock) disable iff (internal_rst)
        cas == !(phase[3:0] >= 4'd8))
        else $error("cas out of its phase window");

    // ba drop to first stolen phi high, three cycles plus half
    a_ba_aec: assert property (@(posedge sys_clock) disable iff (internal_rst)
        $fell(ba) |-> ##112 $fell(aec))
        else $error("aec did not follow ba by three phi cycles");

    a_csync: assert property (@(posedge sys_clock) disable iff (internal_rst || !started)
        csync == !((cycle >= `VIC_HSYNC_FIRST && cycle <= `VIC_HSYNC_LAST) ||
                   line <= `VIC_VSYNC_LAST))
        else $error("csync outside its sync window");

endmodule

bind vic_top vic_sva u_sva (
    .sys_clock (sys_clock), .internal_rst (internal_rst), .clk_phi (clk_phi),
    .phi_fall (phi_fall), .phase (phase), .ba (ba), .aec (aec),
    .csync (csync), .ras (ras), .cas (cas)
);

// File: testbench/vic_tb.sv
`timescale 1ns/1ps

`include "vic_config.svh"

module vic_tb;
    import vic_pkg::*;

    logic sys_clock = 1'b0;
    logic internal_rst, ce, rw;
    logic [5:0]  adi;
    logic [11:0] dbi, dbo, ado;
    logic clk_phi, csync, ado_oe, db_oe, irq, aec, ba, cas, ras, den_n, dir;
    logic [1:0] red, green, blue;
    color_t border_c, background_c;  // colours written by the cpu side
    int pos_cycle = 0;               // raster position from phi falls
    int pos_line = 0;

    vic_top i_dut (.*);

    always #2 sys_clock = ~sys_clock;  // 4 ns

    always @(negedge clk_phi) begin
        if (!internal_rst) begin
            pos_cycle <= (pos_cycle == `VIC_CYCLES_PER_LINE - 1) ? 0 : pos_cycle + 1;
            if (pos_cycle == `VIC_CYCLES_PER_LINE - 1)
                pos_line <= (pos_line == `VIC_LINES_PER_FRAME - 1) ? 0 : pos_line + 1;
        end
    end

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // next clock where phi is sampled at the given level
    task automatic wait_phi(input logic level);
        int n;
        n = 0;
        @(posedge sys_clock);
        while (clk_phi !== level) begin
            n++;
            if (n > 100) report_timeout("a phi edge");
            @(posedge sys_clock);
        end
    endtask

    task automatic write_reg(input reg_addr_e a, input logic [7:0] d);
        wait_phi(1'b0);
        wait_phi(1'b1);
        ce  <= 1'b0;
        rw  <= 1'b0;
        adi <= a;
        dbi <= {4'h0, d};
        wait_phi(1'b0);  // captured at the phi fall
        ce <= 1'b1;
        rw <= 1'b1;
    endtask

    task automatic read_reg(input reg_addr_e a, output logic [7:0] d);
        wait_phi(1'b0);
        wait_phi(1'b1);
        ce  <= 1'b0;
        rw  <= 1'b1;
        adi <= a;
        repeat (2) @(posedge sys_clock);  // still inside phi high
        assert (db_oe === 1'b1) else report_mismatch("db_oe low on a read");
        assert (dir === 1'b1 && den_n === 1'b0) else report_mismatch("transceiver pins on a read");
        assert (dbo[11:8] === 4'hF) else report_mismatch("upper nibble not ones");
        d = dbo[7:0];
        ce <= 1'b1;
    endtask

    function automatic logic [5:0] expected_rgb(input int l, input int c);
        if (l <= `VIC_VSYNC_LAST) return 6'd0;  // blank in vsync
        if (l >= `VIC_DISP_LINE_FIRST && l <= `VIC_DISP_LINE_LAST &&
            c >= `VIC_DISP_CYC_FIRST && c <= `VIC_DISP_CYC_LAST)
            return palette(background_c);
        return palette(border_c);
    endfunction

    initial begin
        logic [7:0] rd;
        int n, fetches;
        logic prev_oe, wrapped;
        internal_rst = 1'b1;
        ce = 1'b1;
        rw = 1'b1;
        adi = '0;
        dbi = '0;
        void'($urandom(15));
        repeat (3) @(posedge sys_clock);
        internal_rst <= 1'b0;
        @(posedge sys_clock);
        assert (clk_phi === 1'b0 && ba && aec && irq && csync && !ado_oe && !db_oe &&
                den_n && !dir)
            else report_mismatch("outputs not at reset values");
        // register access
        border_c = color_t'($urandom % 16);
        background_c = color_t'($urandom % 16);
        write_reg(BORDER, {4'h0, border_c});
        write_reg(BACKGROUND, {4'h0, background_c});
        read_reg(BORDER, rd);
        assert (rd === {4'hF, border_c}) else report_mismatch("border readback");
        read_reg(BACKGROUND, rd);
        assert (rd === {4'hF, background_c}) else report_mismatch("background readback");
        // raster interrupt at line 20
        write_reg(RASTER, 8'd20);
        write_reg(IRQ_ENABLE, 8'h01);
        n = 0;
        while (irq !== 1'b0) begin
            n++;
            if (n > 60000) report_timeout("irq low");
            @(posedge sys_clock);
        end
        assert (pos_line == 20) else report_mismatch("irq not on line 20");
        write_reg(IRQ_STATUS, 8'h01);
        n = 0;
        while (irq !== 1'b1) begin
            n++;
            if (n > 200) report_timeout("irq release");
            @(posedge sys_clock);
        end
        write_reg(IRQ_ENABLE, 8'h00);
        write_reg(RASTER, 8'd24);
        n = 0;
        while (pos_line != 25) begin
            n++;
            if (n > 20000) report_timeout("line 25");
            assert (irq === 1'b1) else report_mismatch("irq low with enable clear");
            @(posedge sys_clock);
        end
        read_reg(RASTER, rd);
        assert (rd === pos_line[7:0]) else report_mismatch("raster read");
        // bad lines, den with yscroll 3
        write_reg(CTRL1, 8'h13);
        n = 0;
        while (ba !== 1'b0) begin
            n++;
            if (n > 60000) report_timeout("ba low");
            @(posedge sys_clock);
        end
        assert (pos_line == 51 && pos_cycle == `VIC_BA_CYCLE)
            else report_mismatch("ba fell at the wrong place");
        fetches = 0;
        prev_oe = 1'b0;
        n = 0;
        while (pos_line != 60) begin
            n++;
            if (n > 40000) report_timeout("line 60");
            if (ado_oe && !prev_oe) begin
                assert (ado === `VIC_VM_BASE + 12'(fetches)) else report_mismatch("fetch address");
                assert (den_n === 1'b0) else report_mismatch("den_n high in a stolen cycle");
                fetches++;
            end
            prev_oe = ado_oe;
            @(posedge sys_clock);
        end
        assert (fetches == 80) else report_mismatch("fetch count over two bad lines");
        // video output through a frame wrap
        wrapped = 1'b0;
        n = 0;
        while (!(wrapped && pos_line == 60)) begin
            n++;
            if (n > 700000) report_timeout("a frame of video");
            if (pos_line == 0) wrapped = 1'b1;
            assert ({red, green, blue} === expected_rgb(pos_line, pos_cycle))
                else report_mismatch("rgb output");
            @(posedge sys_clock);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule
